//--- flist.f
verilog/k005293_pkg.sv
verilog/tile_property_shifter.sv
verilog/sprite_pixel_latch.sv
verilog/layer_priority_mixer.sv
verilog/k005293_priority.sv
tests/k005293_checker.sv
tests/tb_k005293.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_k005293
FLIST     := flist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_k005293.sv
// Testbench for the priority handler
// Clock, reset, strobe sequencing, random pixel stimulus, watchdog and report

`timescale 1ns/1ps
`default_nettype none

module tb_k005293
    import k005293_pkg::*;
();

logic               i_EMU_MCLK;
logic               i_rst_n;
logic               i_EMU_CLK6MPCEN_n;
logic               i_HFLIP;
logic               i_SHIFTA1;
logic               i_SHIFTA2;
logic               i_SHIFTB;
logic               i_ABS_n1H;
logic               i_ABS_n6n7H;
logic               i_ABS_n2n3H;
logic [PIXEL_W-1:0] i_A_PIXEL;
logic [PIXEL_W-1:0] i_B_PIXEL;
logic [15:0]        i_OBJBUF_DATA;
logic               i_A_TRN_n;
logic               i_B_TRN_n;
logic               i_VHFF;
logic [PAL_W-1:0]   i_VC;
logic [3:0]         i_PR;
logic               o_A_FLIP;
logic               o_B_FLIP;
logic [CD_W-1:0]    o_CD;

logic [15:0]        lfsr_q;
int unsigned        fails_before = 0;
int unsigned        tests_run    = 0;
int unsigned        tests_failed = 0;

// Test lengths in clock cycles
int unsigned        reset_cycles  = 8;
int unsigned        push_cycles   = 8;              // Strobe pulses per property load
int unsigned        hold_cycles   = 8;
int unsigned        sprite_cycles = 32;
int unsigned        layer_cycles  = 16;
int unsigned        mix_cycles    = 48;

k005293_priority i_k005293_priority (.*);

always #50 i_EMU_MCLK = ~i_EMU_MCLK;

// Galois LFSR, one step per bit taken
function automatic logic [15:0] rand_bits(input int unsigned nbits);
    logic [15:0] value;
    value = '0;
    for (int unsigned i = 0; i < nbits; i++)
    begin
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        value  = {value[14:0], lfsr_q[0]};
    end
    return value;
endfunction

function automatic int unsigned assertion_failures();
    return i_k005293_priority.u_checker.err_reset + i_k005293_priority.u_checker.err_flip_a +
           i_k005293_priority.u_checker.err_flip_b + i_k005293_priority.u_checker.err_hold +
           i_k005293_priority.u_checker.err_cd;
endfunction

task automatic next_cycle();
    @(posedge i_EMU_MCLK);
    #5;
endtask

// 0 = pixel 3, 1 = pixel 7, 2 = SHIFTA1, 3 = SHIFTA2, 4 = SHIFTB
task automatic pulse_strobe(input int sel);
    i_ABS_n2n3H = (sel != 0);
    i_ABS_n6n7H = (sel != 1);
    i_ABS_n1H   = (sel > 1);
    i_SHIFTA1   = (sel != 2);
    i_SHIFTA2   = (sel != 3);
    i_SHIFTB    = (sel != 4);
    next_cycle();
    i_ABS_n2n3H = 1'b1;
    i_ABS_n6n7H = 1'b1;
    i_ABS_n1H   = 1'b1;
    i_SHIFTA1   = 1'b1;
    i_SHIFTA2   = 1'b1;
    i_SHIFTB    = 1'b1;
endtask

// Layer B end stage first, then layer A, since both share i_PR
task automatic push_props(input logic [3:0] a_pr, input logic [1:0] b_pr,
                          input logic a_flip, input logic b_flip);
    i_PR   = {2'b00, b_pr};
    i_VHFF = b_flip;
    i_VC   = 7'(rand_bits(PAL_W));
    pulse_strobe(0);
    pulse_strobe(1);
    pulse_strobe(0);
    pulse_strobe(4);
    i_PR   = a_pr;
    i_VHFF = a_flip;
    i_VC   = 7'(rand_bits(PAL_W));
    pulse_strobe(0);
    pulse_strobe(1);
    pulse_strobe(2);
    pulse_strobe(3);
endtask

task automatic drive_random_pixels(input int unsigned cycles);
    for (int unsigned n = 0; n < cycles; n++)
    begin
        i_A_PIXEL     = 4'(rand_bits(PIXEL_W));
        i_B_PIXEL     = 4'(rand_bits(PIXEL_W));
        i_A_TRN_n     = 1'(rand_bits(1));
        i_B_TRN_n     = 1'(rand_bits(1));
        i_OBJBUF_DATA = rand_bits(16);
        i_ABS_n1H     = 1'(rand_bits(1));           // Latch load and pixel phase
        i_HFLIP       = 1'(rand_bits(1));
        next_cycle();
    end
    i_ABS_n1H = 1'b1;
endtask

task automatic finish_test(input string name);
    int unsigned fails;
    next_cycle();                                   // Lets the last compare fire
    fails = assertion_failures() - fails_before;
    tests_run++;
    if (fails == 0)
    begin
        $display("test %-15s ok", name);
    end
    else
    begin
        tests_failed++;
        $display("test %-15s %0d assertion failures", name, fails);
    end
    fails_before = assertion_failures();
endtask

////////////////////////////////////////////////////////////
// Test sequence

initial
begin
    lfsr_q            = 16'd96;
    i_EMU_MCLK        = 1'b0;
    i_rst_n           = 1'b0;
    i_EMU_CLK6MPCEN_n = 1'b0;                       // Every edge enabled
    i_HFLIP           = 1'b0;
    i_SHIFTA1         = 1'b1;
    i_SHIFTA2         = 1'b1;
    i_SHIFTB          = 1'b1;
    i_ABS_n1H         = 1'b1;
    i_ABS_n6n7H       = 1'b1;
    i_ABS_n2n3H       = 1'b1;
    i_A_PIXEL         = '0;
    i_B_PIXEL         = '0;
    i_OBJBUF_DATA     = '0;
    i_A_TRN_n         = 1'b1;
    i_B_TRN_n         = 1'b1;
    i_VHFF            = 1'b0;
    i_VC              = '0;
    i_PR              = '0;

    repeat (reset_cycles) next_cycle();
    i_rst_n = 1'b1;
    next_cycle();                                   // First edge out of reset
    finish_test("reset");

    push_props(4'b1001, 2'b10, 1'b1, 1'b0);
    for (int unsigned n = 0; n < hold_cycles; n++)
    begin
        i_PR   = 4'(rand_bits(4));                  // No strobe, flips must hold
        i_VHFF = 1'(rand_bits(1));
        i_VC   = 7'(rand_bits(PAL_W));
        next_cycle();
    end
    push_props(4'b0110, 2'b01, 1'b0, 1'b1);
    finish_test("property_chain");

    push_props(4'b0100, 2'b11, 1'b1, 1'b1);         // Sprite only
    drive_random_pixels(sprite_cycles);
    finish_test("sprite_select");

    push_props(4'b0101, 2'b10, 1'b0, 1'b1);         // A only
    drive_random_pixels(layer_cycles);
    push_props(4'b0000, 2'b01, 1'b1, 1'b0);         // B only
    drive_random_pixels(layer_cycles);
    finish_test("single_layer");

    push_props(4'b1101, 2'b01, 1'b0, 1'b0);         // A over B
    drive_random_pixels(mix_cycles);
    finish_test("priority_a_b");

    $display("tests run %0d, tests failed %0d, assertion failures %0d",
             tests_run, tests_failed, assertion_failures());
    if (tests_failed == 0)
    begin
        $display("Simulation PASSED");
    end
    else
    begin
        $display("Simulation FAILED");
    end
    $finish;
end

initial
begin
    int unsigned budget;
    budget = reset_cycles + 1 + 6 * push_cycles + hold_cycles + sprite_cycles +
             2 * layer_cycles + mix_cycles + 5 + 50;
    #(budget * 100);
    $display("Watchdog timeout, the run did not finish within %0d cycles", budget);
    $display("Simulation FAILED");
    $finish;
end

endmodule

`default_nettype wire

//--- tests/k005293_checker.sv
// Concurrent assertions bound to the priority handler top level
// Small reference model of the property chains, sprite latch and checked modes

`timescale 1ns/1ps
`default_nettype none

module k005293_checker
    import k005293_pkg::*;
(
    input  wire logic               i_EMU_MCLK,
    input  wire logic               i_rst_n,
    input  wire logic               i_EMU_CLK6MPCEN_n,
    input  wire logic               i_HFLIP,
    input  wire logic               i_SHIFTA1,
    input  wire logic               i_SHIFTA2,
    input  wire logic               i_SHIFTB,
    input  wire logic               i_ABS_n1H,
    input  wire logic               i_ABS_n6n7H,
    input  wire logic               i_ABS_n2n3H,
    input  wire logic [PIXEL_W-1:0] i_A_PIXEL,
    input  wire logic [PIXEL_W-1:0] i_B_PIXEL,
    input  wire logic [15:0]        i_OBJBUF_DATA,
    input  wire logic               i_A_TRN_n,
    input  wire logic               i_B_TRN_n,
    input  wire logic               i_VHFF,
    input  wire logic [PAL_W-1:0]   i_VC,
    input  wire logic [3:0]         i_PR,
    input  wire logic               o_A_FLIP,
    input  wire logic               o_B_FLIP,
    input  wire logic [CD_W-1:0]    o_CD
);

tma_prop_t        ref_a [TMA_STAGES];
tmb_prop_t        ref_b [TMB_STAGES];
logic [OBJ_W-1:0] ref_odd;
logic [OBJ_W-1:0] ref_even;
logic [OBJ_W-1:0] obj_now;
logic             pix3;                             // Active high here
logic             pix7;
logic             a_clear;
logic             b_clear;
logic [CD_W-1:0]  exp_cd;
logic             exp_vld;                          // Mode is one of the modelled four

int unsigned      err_reset  = 0;
int unsigned      err_flip_a = 0;
int unsigned      err_flip_b = 0;
int unsigned      err_hold   = 0;
int unsigned      err_cd     = 0;

assign pix3    = !i_ABS_n2n3H && !i_ABS_n1H;
assign pix7    = !i_ABS_n6n7H && !i_ABS_n1H;
assign obj_now = (i_ABS_n1H ^ i_HFLIP) ? ref_even : ref_odd;
assign a_clear = !i_A_TRN_n;
assign b_clear = !i_B_TRN_n;

////////////////////////////////////////////////////////////
// Reference model

always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        for (int i = 0; i < TMA_STAGES; i++)
        begin
            ref_a[i] <= '0;
        end
        for (int i = 0; i < TMB_STAGES; i++)
        begin
            ref_b[i] <= '0;
        end
        ref_odd  <= '0;
        ref_even <= '0;
        exp_cd   <= '0;
        exp_vld  <= 1'b0;
    end
    else if (!i_EMU_CLK6MPCEN_n)
    begin
        if (pix3)
        begin
            ref_a[0] <= '{pr: i_PR, flip: i_VHFF, palette: i_VC};
            ref_b[1] <= ref_b[0];
        end
        if (pix7)
        begin
            ref_a[1] <= ref_a[0];
            ref_b[0] <= '{pr: i_PR[1:0], flip: i_VHFF, palette: i_VC};
        end
        if (!i_SHIFTA1)
        begin
            ref_a[2] <= ref_a[1];
        end
        if (!i_SHIFTA2)
        begin
            ref_a[3] <= ref_a[2];
        end
        if (!i_SHIFTB)
        begin
            ref_b[2] <= ref_b[1];
        end
        if (!i_ABS_n1H)
        begin
            ref_odd  <= i_OBJBUF_DATA[15:8];
            ref_even <= i_OBJBUF_DATA[7:0];
        end

        exp_vld <= 1'b1;
        if (ref_a[3].pr == 4'b0101 ||
            (ref_a[3].pr == 4'b1101 && ref_b[2].pr == 2'b01 && !(a_clear && !b_clear)))
        begin
            exp_cd <= {ref_a[3].palette, i_A_PIXEL};      // A, or A over B
        end
        else if ((ref_a[3].pr == 4'b0000 || ref_a[3].pr == 4'b1101) && ref_b[2].pr == 2'b01)
        begin
            exp_cd <= {ref_b[2].palette, i_B_PIXEL};      // B, or B through clear A
        end
        else if (ref_a[3].pr == 4'b0100)
        begin
            exp_cd <= {3'b000, obj_now};                  // Sprite only
        end
        else
        begin
            exp_vld <= 1'b0;
        end
    end
end

////////////////////////////////////////////////////////////
// Assertions

// During reset and after the first edge out of it
a_reset: assert property (@(posedge i_EMU_MCLK)
    (!i_rst_n || !$past(i_rst_n, 2)) |-> (o_CD == '0 && !o_A_FLIP && !o_B_FLIP))
    else
    begin
        $error("[ERROR] reset expected 000/0/0 actual %h/%0b/%0b",
               $sampled(o_CD), $sampled(o_A_FLIP), $sampled(o_B_FLIP));
        err_reset++;
    end

a_flip_a: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
    o_A_FLIP == ref_a[TMA_STAGES-1].flip)
    else
    begin
        $error("[ERROR] flip_a expected %0b actual %0b",
               $sampled(ref_a[TMA_STAGES-1].flip), $sampled(o_A_FLIP));
        err_flip_a++;
    end

a_flip_b: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
    o_B_FLIP == ref_b[TMB_STAGES-1].flip)
    else
    begin
        $error("[ERROR] flip_b expected %0b actual %0b",
               $sampled(ref_b[TMB_STAGES-1].flip), $sampled(o_B_FLIP));
        err_flip_b++;
    end

a_flip_hold: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
    (!pix3 && !pix7 && i_SHIFTA1 && i_SHIFTA2 && i_SHIFTB) |=> $stable({o_A_FLIP, o_B_FLIP}))
    else
    begin
        $error("Flip output changed on an edge where no stage strobe was active");
        err_hold++;
    end

a_cd: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
    exp_vld |-> o_CD == exp_cd)
    else
    begin
        $error("[ERROR] palette_code expected %h actual %h",
               $sampled(exp_cd), $sampled(o_CD));
        err_cd++;
    end

endmodule

bind k005293_priority k005293_checker u_checker (.*);

`default_nettype wire

//--- verilog/k005293_priority.sv
// Top level of the tilemap/sprite priority handler
// Strobe decode, two property shifters, sprite latch and layer mixer

`timescale 1ns/1ps
`default_nettype none

module k005293_priority
    import k005293_pkg::*;
(
    input  wire logic               i_EMU_MCLK,
    input  wire logic               i_rst_n,
    input  wire logic               i_EMU_CLK6MPCEN_n,

    input  wire logic               i_HFLIP,

    input  wire logic               i_SHIFTA1,
    input  wire logic               i_SHIFTA2,
    input  wire logic               i_SHIFTB,

    input  wire logic               i_ABS_n1H,
    input  wire logic               i_ABS_n6n7H,
    input  wire logic               i_ABS_n2n3H,

    input  wire logic [PIXEL_W-1:0] i_A_PIXEL,
    input  wire logic [PIXEL_W-1:0] i_B_PIXEL,
    input  wire logic [15:0]        i_OBJBUF_DATA,

    input  wire logic               i_A_TRN_n,
    input  wire logic               i_B_TRN_n,

    input  wire logic               i_VHFF,
    input  wire logic [PAL_W-1:0]   i_VC,
    input  wire logic [3:0]         i_PR,

    output logic                    o_A_FLIP,
    output logic                    o_B_FLIP,
    output logic      [CD_W-1:0]    o_CD
);

////////////////////////////////////////////////////////////
// Strobes and stage loads, all active low

logic                  pix3_stb_n;
logic                  pix7_stb_n;
logic [TMA_STAGES-1:0] tma_load_n;
logic [TMB_STAGES-1:0] tmb_load_n;
tma_prop_t             tma_in;
tmb_prop_t             tmb_in;
tma_prop_t             tma_q;
tmb_prop_t             tmb_q;
logic [OBJ_W-1:0]      obj_pixel;

assign pix3_stb_n = i_ABS_n2n3H | i_ABS_n1H;         // Pixel 3
assign pix7_stb_n = i_ABS_n6n7H | i_ABS_n1H;         // Pixel 7

// Layer B takes its first stage half a character after layer A
assign tma_load_n = {i_SHIFTA2, i_SHIFTA1, pix7_stb_n, pix3_stb_n};
assign tmb_load_n = {i_SHIFTB, pix3_stb_n, pix7_stb_n};

assign tma_in = '{pr: i_PR, flip: i_VHFF, palette: i_VC};
assign tmb_in = '{pr: i_PR[1:0], flip: i_VHFF, palette: i_VC};

tile_property_shifter #(.payload_t(tma_prop_t), .NUM_STAGES(TMA_STAGES)) u_tma_shifter
(
    .i_EMU_MCLK        (i_EMU_MCLK),
    .i_rst_n           (i_rst_n),
    .i_EMU_CLK6MPCEN_n (i_EMU_CLK6MPCEN_n),
    .i_load            (tma_load_n),
    .i_data            (tma_in),
    .o_data            (tma_q)
);

tile_property_shifter #(.payload_t(tmb_prop_t), .NUM_STAGES(TMB_STAGES)) u_tmb_shifter
(
    .i_EMU_MCLK        (i_EMU_MCLK),
    .i_rst_n           (i_rst_n),
    .i_EMU_CLK6MPCEN_n (i_EMU_CLK6MPCEN_n),
    .i_load            (tmb_load_n),
    .i_data            (tmb_in),
    .o_data            (tmb_q)
);

assign o_A_FLIP = tma_q.flip;                       // To tile pixel serializers
assign o_B_FLIP = tmb_q.flip;

sprite_pixel_latch u_obj_latch
(
    .i_EMU_MCLK        (i_EMU_MCLK),
    .i_rst_n           (i_rst_n),
    .i_EMU_CLK6MPCEN_n (i_EMU_CLK6MPCEN_n),
    .i_ABS_n1H         (i_ABS_n1H),
    .i_HFLIP           (i_HFLIP),
    .i_OBJBUF_DATA     (i_OBJBUF_DATA),
    .o_obj_pixel       (obj_pixel)
);

layer_priority_mixer u_mixer
(
    .i_EMU_MCLK        (i_EMU_MCLK),
    .i_rst_n           (i_rst_n),
    .i_EMU_CLK6MPCEN_n (i_EMU_CLK6MPCEN_n),
    .i_tma             (tma_q),
    .i_tmb             (tmb_q),
    .i_A_PIXEL         (i_A_PIXEL),
    .i_B_PIXEL         (i_B_PIXEL),
    .i_A_TRN_n         (i_A_TRN_n),
    .i_B_TRN_n         (i_B_TRN_n),
    .i_obj_pixel       (obj_pixel),
    .o_CD              (o_CD)
);

endmodule

`default_nettype wire

//--- verilog/layer_priority_mixer.sv
// Priority mode decoder and layer select
// Registers the winning layer's palette code on the pixel enable

`timescale 1ns/1ps
`default_nettype none

module layer_priority_mixer
    import k005293_pkg::*;
(
    input  wire logic               i_EMU_MCLK,
    input  wire logic               i_rst_n,
    input  wire logic               i_EMU_CLK6MPCEN_n,

    input  wire tma_prop_t          i_tma,
    input  wire tmb_prop_t          i_tmb,
    input  wire logic [PIXEL_W-1:0] i_A_PIXEL,
    input  wire logic [PIXEL_W-1:0] i_B_PIXEL,
    input  wire logic               i_A_TRN_n,
    input  wire logic               i_B_TRN_n,
    input  wire logic [OBJ_W-1:0]   i_obj_pixel,

    output logic      [CD_W-1:0]    o_CD
);

prmode_t    priority_mode;
logic       obj_trn_n;
logic [2:0] trn;                                    // {A, B, OBJ}, 1 = transparent
layer_t     layer;

////////////////////////////////////////////////////////////
// Mode decode from {B pr[1:0], A pr[3:0]}

always_comb
begin
    casez ({i_tmb.pr, i_tma.pr})
        6'b??_0101: priority_mode = PRMODE_A;
        6'b?1_1101: priority_mode = PRMODE_A_B;
        6'b?1_1111: priority_mode = PRMODE_A_B_O;
        6'b00_1101: priority_mode = PRMODE_A_BMO;
        6'b??_0111: priority_mode = PRMODE_A_O1;
        6'b00_1111: priority_mode = PRMODE_A_O2;
        6'b10_1111: priority_mode = PRMODE_A_O_B;
        6'b01_00??: priority_mode = PRMODE_B;
        6'b01_10?1: priority_mode = PRMODE_B_A;
        6'b11_10?1: priority_mode = PRMODE_B_A_O;
        6'b11_00??: priority_mode = PRMODE_B_O;
        6'b11_1000: priority_mode = PRMODE_B_O;     // Alias
        6'b11_1010: priority_mode = PRMODE_B_O_A;
        6'b00_00??: priority_mode = PRMODE_O;
        6'b00_1?00: priority_mode = PRMODE_O;       // Alias
        6'b??_0100: priority_mode = PRMODE_O;       // Alias
        6'b??_0110: priority_mode = PRMODE_O_A;
        6'b00_1110: priority_mode = PRMODE_O_A;     // Alias
        6'b10_1110: priority_mode = PRMODE_O_A_B;
        6'b10_00??: priority_mode = PRMODE_O_B;
        6'b10_1000: priority_mode = PRMODE_O_B;     // Alias
        6'b10_1010: priority_mode = PRMODE_O_B_A;
        6'b10_1101: priority_mode = PRMODE_A_BMO_B;
        6'b?1_1100: priority_mode = PRMODE_APB_O;
        6'b?1_1110: priority_mode = PRMODE_APB_O_A;
        6'b01_1000: priority_mode = PRMODE_B_AMO;
        6'b01_1010: priority_mode = PRMODE_B_AMO_A;
        6'b00_10?1: priority_mode = PRMODE_BPA_O;
        6'b10_10?1: priority_mode = PRMODE_BPA_O_B;
        6'b10_1100: priority_mode = PRMODE_O_APB;
        6'b00_1010: priority_mode = PRMODE_O_BPA;
        default:    priority_mode = PRMODE_A;       // Undecoded codes show layer A
    endcase
end

////////////////////////////////////////////////////////////
// Winner lookup

// Sprite colour 0 of each palette is see-through
assign obj_trn_n = |i_obj_pixel[3:0];
assign trn       = ~{i_A_TRN_n, i_B_TRN_n, obj_trn_n};
assign layer     = PRIO_TABLE[priority_mode][trn];

////////////////////////////////////////////////////////////
// Output register

always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        o_CD <= '0;
    end
    else if (!i_EMU_CLK6MPCEN_n)
    begin
        case (layer)
            LAYER_TMA:
            begin
                o_CD <= {i_tma.palette, i_A_PIXEL};
            end
            LAYER_TMB:
            begin
                o_CD <= {i_tmb.palette, i_B_PIXEL};
            end
            default:
            begin
                o_CD <= {{(CD_W-OBJ_W){1'b0}}, i_obj_pixel}; // Sprite carries own palette
            end
        endcase
    end
end

endmodule

`default_nettype wire

//--- verilog/sprite_pixel_latch.sv
// Sprite buffer word latch
// Holds an even/odd pixel pair and picks one by pixel phase and flip

`timescale 1ns/1ps
`default_nettype none

module sprite_pixel_latch
    import k005293_pkg::*;
(
    input  wire logic             i_EMU_MCLK,
    input  wire logic             i_rst_n,
    input  wire logic             i_EMU_CLK6MPCEN_n,

    input  wire logic             i_ABS_n1H,        // Pixel phase, low on odd half
    input  wire logic             i_HFLIP,
    input  wire logic [15:0]      i_OBJBUF_DATA,

    output logic      [OBJ_W-1:0] o_obj_pixel
);

logic [OBJ_W-1:0] even_pixel_q;
logic [OBJ_W-1:0] odd_pixel_q;
logic             pick_odd;

always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        even_pixel_q <= '0;
        odd_pixel_q  <= '0;
    end
    else if (!i_EMU_CLK6MPCEN_n)
    begin
        if (!i_ABS_n1H)
        begin
            odd_pixel_q  <= i_OBJBUF_DATA[15:8];    // Buffer A half
            even_pixel_q <= i_OBJBUF_DATA[7:0];     // Buffer B half
        end
    end
end

// Horizontal flip swaps which half of the pair comes out first
assign pick_odd    = ~i_ABS_n1H ^ i_HFLIP;
assign o_obj_pixel = pick_odd ? odd_pixel_q : even_pixel_q;

endmodule

`default_nettype wire

//--- verilog/tile_property_shifter.sv
// Strobed delay line for one tilemap layer's properties
// Payload type and stage count set per instance

`timescale 1ns/1ps
`default_nettype none

module tile_property_shifter
    import k005293_pkg::*;
#(
    parameter type payload_t  = logic [7:0],
    parameter int  NUM_STAGES = 2
)
(
    input  wire logic                  i_EMU_MCLK,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_EMU_CLK6MPCEN_n,

    input  wire logic [NUM_STAGES-1:0] i_load,      // Active low, bit 0 = first stage
    input  wire payload_t              i_data,
    output payload_t                   o_data
);

payload_t stage_q [NUM_STAGES];

always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        for (int i = 0; i < NUM_STAGES; i++)
        begin
            stage_q[i] <= '0;
        end
    end
    else if (!i_EMU_CLK6MPCEN_n)
    begin
        if (!i_load[0])
        begin
            stage_q[0] <= i_data;                   // Entry from tile fetch
        end

        for (int i = 1; i < NUM_STAGES; i++)
        begin
            if (!i_load[i])
            begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end
end

assign o_data = stage_q[NUM_STAGES-1];              // Last stage feeds the mixer

endmodule

`default_nettype wire

//--- verilog/k005293_pkg.sv
// Shared definitions for the priority handler
// Widths, layer and mode codes, tile property structs, mode/transparency table

`default_nettype none

package k005293_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and counts

    localparam int PIXEL_W    = 4;              // Tilemap pixel
    localparam int PAL_W      = 7;              // Tile palette
    localparam int OBJ_W      = 8;              // Sprite pixel
    localparam int CD_W       = 11;             // Palette code out
    localparam int MODE_W     = 5;
    localparam int NUM_MODES  = 26;

    localparam int TMA_STAGES = 4;              // Layer A delay stages
    localparam int TMB_STAGES = 3;              // Layer B delay stages

    ////////////////////////////////////////////////////////////
    // Layer and mode codes

    typedef enum logic [1:0] {
        LAYER_TMA = 2'd0,
        LAYER_TMB = 2'd1,
        LAYER_OBJ = 2'd2
    } layer_t;

    // Names read as "X over Y", M = masked, P = punched
    typedef enum logic [MODE_W-1:0] {
        PRMODE_A       = 5'd0,  PRMODE_A_B     = 5'd1,
        PRMODE_A_B_O   = 5'd2,  PRMODE_A_BMO   = 5'd3,
        PRMODE_A_O1    = 5'd4,  PRMODE_A_O2    = 5'd5,
        PRMODE_A_O_B   = 5'd6,  PRMODE_B       = 5'd7,
        PRMODE_B_A     = 5'd8,  PRMODE_B_A_O   = 5'd9,
        PRMODE_B_O     = 5'd10, PRMODE_B_O_A   = 5'd11,
        PRMODE_O       = 5'd12, PRMODE_O_A     = 5'd13,
        PRMODE_O_A_B   = 5'd14, PRMODE_O_B     = 5'd15,
        PRMODE_O_B_A   = 5'd16, PRMODE_A_BMO_B = 5'd17,
        PRMODE_APB_O   = 5'd18, PRMODE_APB_O_A = 5'd19,
        PRMODE_B_AMO   = 5'd20, PRMODE_B_AMO_A = 5'd21,
        PRMODE_BPA_O   = 5'd22, PRMODE_BPA_O_B = 5'd23,
        PRMODE_O_APB   = 5'd24, PRMODE_O_BPA   = 5'd25
    } prmode_t;

    ////////////////////////////////////////////////////////////
    // Tile properties, in the bit order of {PR, VHFF, VC}

    typedef struct packed {
        logic [3:0]       pr;
        logic             flip;
        logic [PAL_W-1:0] palette;
    } tma_prop_t;

    // Upper PR bits of layer B have no effect in the chip
    typedef struct packed {
        logic [1:0]       pr;
        logic             flip;
        logic [PAL_W-1:0] palette;
    } tmb_prop_t;

    ////////////////////////////////////////////////////////////
    // Winner per mode, indexed by transparency {A, B, OBJ}, 1 = clear
    // Row elements run from index 7 down to 0

    typedef layer_t [7:0] prio_row_t;

    localparam prio_row_t PRIO_TABLE [NUM_MODES] = '{
        '{LAYER_TMA, LAYER_TMA, LAYER_TMA, LAYER_TMA,
          LAYER_TMA, LAYER_TMA, LAYER_TMA, LAYER_TMA},     // A
        '{LAYER_TMA, LAYER_TMA, LAYER_TMB, LAYER_TMB,
          LAYER_TMA, LAYER_TMA, LAYER_TMA, LAYER_TMA},     // A_B
        '{LAYER_TMA, LAYER_OBJ, LAYER_TMB, LAYER_TMB,
          LAYER_TMA, LAYER_TMA, LAYER_TMA, LAYER_TMA},     // A_B_O
        '{LAYER_TMA, LAYER_TMA, LAYER_OBJ, LAYER_OBJ,
          LAYER_TMA, LAYER_TMA, LAYER_TMA, LAYER_TMA},     // A_BMO
        '{LAYER_TMA, LAYER_OBJ, LAYER_TMA, LAYER_OBJ,
          LAYER_TMA, LAYER_TMA, LAYER_TMA, LAYER_TMA},     // A_O1
        '{LAYER_TMA, LAYER_OBJ, LAYER_OBJ, LAYER_OBJ,
          LAYER_TMA, LAYER_TMA, LAYER_TMA, LAYER_TMA},     // A_O2
        '{LAYER_TMA, LAYER_OBJ, LAYER_TMB, LAYER_OBJ,
          LAYER_TMA, LAYER_TMA, LAYER_TMA, LAYER_TMA},     // A_O_B
        '{LAYER_TMB, LAYER_TMB, LAYER_TMB, LAYER_TMB,
          LAYER_TMB, LAYER_TMB, LAYER_TMB, LAYER_TMB},     // B
        '{LAYER_TMB, LAYER_TMB, LAYER_TMB, LAYER_TMB,
          LAYER_TMA, LAYER_TMA, LAYER_TMB, LAYER_TMB},     // B_A
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_TMB,
          LAYER_TMA, LAYER_TMA, LAYER_TMB, LAYER_TMB},     // B_A_O
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_TMB,
          LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_TMB},     // B_O
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_TMB,
          LAYER_TMA, LAYER_OBJ, LAYER_TMB, LAYER_TMB},     // B_O_A
        '{LAYER_OBJ, LAYER_OBJ, LAYER_OBJ, LAYER_OBJ,
          LAYER_OBJ, LAYER_OBJ, LAYER_OBJ, LAYER_OBJ},     // O
        '{LAYER_OBJ, LAYER_OBJ, LAYER_OBJ, LAYER_OBJ,
          LAYER_TMA, LAYER_OBJ, LAYER_TMA, LAYER_OBJ},     // O_A
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_OBJ,
          LAYER_TMA, LAYER_OBJ, LAYER_TMA, LAYER_OBJ},     // O_A_B
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_OBJ,
          LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_OBJ},     // O_B
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_OBJ,
          LAYER_TMA, LAYER_OBJ, LAYER_TMB, LAYER_OBJ},     // O_B_A
        '{LAYER_TMA, LAYER_TMA, LAYER_TMB, LAYER_OBJ,
          LAYER_TMA, LAYER_TMA, LAYER_TMA, LAYER_TMA},     // A_BMO_B
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_TMB,
          LAYER_OBJ, LAYER_OBJ, LAYER_OBJ, LAYER_OBJ},     // APB_O
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_TMB,
          LAYER_TMA, LAYER_OBJ, LAYER_TMA, LAYER_OBJ},     // APB_O_A
        '{LAYER_TMB, LAYER_TMB, LAYER_TMB, LAYER_TMB,
          LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_TMB},     // B_AMO
        '{LAYER_TMB, LAYER_TMB, LAYER_TMB, LAYER_TMB,
          LAYER_TMA, LAYER_OBJ, LAYER_TMB, LAYER_TMB},     // B_AMO_A
        '{LAYER_OBJ, LAYER_OBJ, LAYER_OBJ, LAYER_OBJ,
          LAYER_TMA, LAYER_TMA, LAYER_OBJ, LAYER_OBJ},     // BPA_O
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_OBJ,
          LAYER_TMA, LAYER_TMA, LAYER_TMB, LAYER_OBJ},     // BPA_O_B
        '{LAYER_OBJ, LAYER_OBJ, LAYER_TMB, LAYER_OBJ,
          LAYER_OBJ, LAYER_OBJ, LAYER_OBJ, LAYER_OBJ},     // O_APB
        '{LAYER_OBJ, LAYER_OBJ, LAYER_OBJ, LAYER_OBJ,
          LAYER_TMA, LAYER_OBJ, LAYER_OBJ, LAYER_OBJ}      // O_BPA
    };

endpackage

`default_nettype wire
